/* compile.f */
source/rv32i_mem_pkg.sv
source/stage_reg.sv
source/mem_access.sv
source/data_sram.sv
source/load_align.sv
source/mem_stage_top.sv
testbench/mem_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds mem_stage_tb with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mem_stage_tb \
    -f compile.f --Mdir obj_dir -o mem_stage_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/mem_stage_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "tests failed" "$log"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
echo "simulation ok"
exit 0

/* source/data_sram.sv */
// word memory, 2**addr_bits words, byte-lane writes, reads registered one cycle
// contents start at zero and survive reset; read returns the old word on a write
`default_nettype none

module data_sram
    import rv32i_mem_pkg::*;
#(
    parameter int addr_bits = 8
) (
    input  wire logic             clk,
    input  wire logic             req,
    input  wire logic [xlen-1:0]  addr,
    input  wire logic [3:0]       rmask,
    input  wire logic [3:0]       wmask,
    input  wire logic [xlen-1:0]  wdata,
    output logic [xlen-1:0]       rdata
);

    logic [xlen-1:0]      mem [2**addr_bits];
    logic [addr_bits-1:0] word_idx;
    logic [xlen-1:0]      rd_word;

    // byte offset bits dropped
    assign word_idx = addr[addr_bits+1:2];
    assign rd_word  = mem[word_idx];

    initial begin
        for (int i = 0; i < 2**addr_bits; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wmask[lane]) begin
                    mem[word_idx][8*lane +: 8] <= wdata[8*lane +: 8];
                end
                // unread lanes come back as zero
                rdata[8*lane +: 8] <= rmask[lane] ? rd_word[8*lane +: 8] : 8'h00;
            end
        end
    end

    // masks from the memory stage must be quiet without a strobe
    assert property (@(posedge clk) !req |-> (rmask == 4'b0000 && wmask == 4'b0000))
        else $error("data_sram: mask active without request");

endmodule

`default_nettype wire

/* source/load_align.sv */
// writeback: lane select and extension for loads, alu_out for everything else
// offset must already be aligned for halfword and word loads
`default_nettype none

module load_align
    import rv32i_mem_pkg::*;
(
    input  wire logic             valid,
    input  wire logic             mem_re,
    input  wire logic             reg_we,
    input  wire mem_f3_t          funct3,
    input  wire logic [1:0]       offset,
    input  wire logic [4:0]       rd,
    input  wire logic [xlen-1:0]  alu_out,
    input  wire logic [xlen-1:0]  rdata,
    output logic                  wb_valid,
    output logic                  rd_we,
    output logic [4:0]            rd_addr,
    output logic [xlen-1:0]       rd_wdata
);

    logic [xlen-1:0] shifted;

    // addressed lane down to bit 0
    assign shifted = rdata >> {offset, 3'b000};

    always_comb begin
        if (mem_re) begin
            case (funct3)
                f3_b:    rd_wdata = {{(xlen-8){shifted[7]}}, shifted[7:0]};
                f3_bu:   rd_wdata = {{(xlen-8){1'b0}}, shifted[7:0]};
                f3_h:    rd_wdata = {{(xlen-16){shifted[15]}}, shifted[15:0]};
                f3_hu:   rd_wdata = {{(xlen-16){1'b0}}, shifted[15:0]};
                default: rd_wdata = shifted;
            endcase
        end else begin
            rd_wdata = alu_out;
        end
    end

    assign wb_valid = valid;
    assign rd_addr  = rd;

    // x0 never written
    assign rd_we = valid && reg_we && (rd != 5'd0);

endmodule

`default_nettype wire

/* source/mem_access.sv */
// memory stage: aligned word address, byte masks, lane-replicated store data
// misaligned halfword/word accesses are not supported and are flagged
`default_nettype none

module mem_access
    import rv32i_mem_pkg::*;
(
    input  wire logic             move,
    input  wire logic             valid,
    input  wire logic             mem_we,
    input  wire logic             mem_re,
    input  wire mem_f3_t          funct3,
    input  wire logic [xlen-1:0]  alu_out,
    input  wire logic [xlen-1:0]  rs2_v,
    output logic                  dmem_req,
    output logic [xlen-1:0]       dmem_addr,
    output logic [3:0]            dmem_rmask,
    output logic [3:0]            dmem_wmask,
    output logic [xlen-1:0]       dmem_wdata
);

    logic [1:0] offset;
    logic [3:0] lane_pat;
    logic [3:0] lane_mask;

    assign offset = alu_out[1:0];

    // strobe only for a live load or store on an advancing edge
    assign dmem_req = move && valid && (mem_we || mem_re);

    assign dmem_addr = {alu_out[xlen-1:2], 2'b00};

    // lanes touched by the access width
    always_comb begin
        case (funct3)
            f3_b, f3_bu: lane_pat = 4'b0001;
            f3_h, f3_hu: lane_pat = 4'b0011;
            default:     lane_pat = 4'b1111;
        endcase
    end

    assign lane_mask = lane_pat << offset;

    assign dmem_rmask = (dmem_req && mem_re) ? lane_mask : 4'b0000;
    assign dmem_wmask = (dmem_req && mem_we) ? lane_mask : 4'b0000;

    // store data copied into every lane, the mask picks
    always_comb begin
        case (funct3)
            f3_b:    dmem_wdata = {4{rs2_v[7:0]}};
            f3_h:    dmem_wdata = {2{rs2_v[15:0]}};
            default: dmem_wdata = rs2_v;
        endcase
    end

    // access contract, checked only when a request goes out
    always_comb begin
        if (dmem_req) begin
            assert (!(mem_we && mem_re))
                else $error("mem_access: load and store requested together");
            if (funct3 == f3_h || funct3 == f3_hu) begin
                assert (offset[0] == 1'b0)
                    else $error("mem_access: misaligned halfword at %h", alu_out);
            end
            if (funct3 == f3_w) begin
                assert (offset == 2'b00)
                    else $error("mem_access: misaligned word at %h", alu_out);
            end
        end
    end

endmodule

`default_nettype wire

/* source/mem_stage_top.sv */
// EX/MEM -> memory -> MEM/WB -> writeback, two move-high edges of latency
// move low freezes every stage; the memory answers in one cycle
`default_nettype none

module mem_stage_top
    import rv32i_mem_pkg::*;
#(
    parameter int addr_bits = 8
) (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             in_valid,
    input  wire logic             in_mem_we,
    input  wire logic             in_mem_re,
    input  wire logic [2:0]       in_funct3,
    input  wire logic [xlen-1:0]  in_alu_out,
    input  wire logic [xlen-1:0]  in_rs2_v,
    input  wire logic [4:0]       in_rd,
    input  wire logic             move,
    output logic                  wb_valid,
    output logic                  rd_we,
    output logic [4:0]            rd_addr,
    output logic [xlen-1:0]       rd_wdata
);

    ex_mem_payload_t  ex_mem_in;
    ex_mem_payload_t  ex_mem_q;
    logic             ex_mem_valid;

    mem_wb_payload_t  mem_wb_in;
    mem_wb_payload_t  mem_wb_q;
    logic             mem_wb_valid;

    logic             dmem_req;
    logic [xlen-1:0]  dmem_addr;
    logic [3:0]       dmem_rmask;
    logic [3:0]       dmem_wmask;
    logic [xlen-1:0]  dmem_wdata;
    logic [xlen-1:0]  dmem_rdata;

    always_comb begin
        ex_mem_in.mem_we  = in_mem_we;
        ex_mem_in.mem_re  = in_mem_re;
        ex_mem_in.funct3  = mem_f3_t'(in_funct3);
        ex_mem_in.alu_out = in_alu_out;
        ex_mem_in.rs2_v   = in_rs2_v;
        ex_mem_in.rd      = in_rd;
    end

    stage_reg #(.payload_t(ex_mem_payload_t)) ex_mem_reg (
        .clk         (clk),
        .reset       (reset),
        .move        (move),
        .in_valid    (in_valid),
        .in_payload  (ex_mem_in),
        .out_valid   (ex_mem_valid),
        .out_payload (ex_mem_q)
    );

    mem_access mem_access (
        .move       (move),
        .valid      (ex_mem_valid),
        .mem_we     (ex_mem_q.mem_we),
        .mem_re     (ex_mem_q.mem_re),
        .funct3     (ex_mem_q.funct3),
        .alu_out    (ex_mem_q.alu_out),
        .rs2_v      (ex_mem_q.rs2_v),
        .dmem_req   (dmem_req),
        .dmem_addr  (dmem_addr),
        .dmem_rmask (dmem_rmask),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata)
    );

    data_sram #(.addr_bits(addr_bits)) data_sram (
        .clk   (clk),
        .req   (dmem_req),
        .addr  (dmem_addr),
        .rmask (dmem_rmask),
        .wmask (dmem_wmask),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata)
    );

    // stores write no register
    always_comb begin
        mem_wb_in.mem_re  = ex_mem_q.mem_re;
        mem_wb_in.reg_we  = !ex_mem_q.mem_we;
        mem_wb_in.funct3  = ex_mem_q.funct3;
        mem_wb_in.offset  = ex_mem_q.alu_out[1:0];
        mem_wb_in.rd      = ex_mem_q.rd;
        mem_wb_in.alu_out = ex_mem_q.alu_out;
    end

    stage_reg #(.payload_t(mem_wb_payload_t)) mem_wb_reg (
        .clk         (clk),
        .reset       (reset),
        .move        (move),
        .in_valid    (ex_mem_valid),
        .in_payload  (mem_wb_in),
        .out_valid   (mem_wb_valid),
        .out_payload (mem_wb_q)
    );

    load_align load_align (
        .valid    (mem_wb_valid),
        .mem_re   (mem_wb_q.mem_re),
        .reg_we   (mem_wb_q.reg_we),
        .funct3   (mem_wb_q.funct3),
        .offset   (mem_wb_q.offset),
        .rd       (mem_wb_q.rd),
        .alu_out  (mem_wb_q.alu_out),
        .rdata    (dmem_rdata),
        .wb_valid (wb_valid),
        .rd_we    (rd_we),
        .rd_addr  (rd_addr),
        .rd_wdata (rd_wdata)
    );

endmodule

`default_nettype wire

/* source/rv32i_mem_pkg.sv */
// widths, funct3 codes and stage payloads for the memory slice
// stores use only f3_b, f3_h and f3_w
`default_nettype none

package rv32i_mem_pkg;

    // data and address width
    localparam int xlen = 32;

    // load/store width and sign
    typedef enum logic [2:0] {
        f3_b  = 3'd0,
        f3_h  = 3'd1,
        f3_w  = 3'd2,
        f3_bu = 3'd4,
        f3_hu = 3'd5
    } mem_f3_t;

    // EX/MEM payload
    typedef struct packed {
        logic            mem_we;
        logic            mem_re;
        mem_f3_t         funct3;
        // byte address, or ALU result for non-memory ops
        logic [xlen-1:0] alu_out;
        logic [xlen-1:0] rs2_v;
        logic [4:0]      rd;
    } ex_mem_payload_t;

    // MEM/WB payload
    typedef struct packed {
        logic            mem_re;
        logic            reg_we;
        mem_f3_t         funct3;
        // lane of the first addressed byte
        logic [1:0]      offset;
        logic [4:0]      rd;
        logic [xlen-1:0] alu_out;
    } mem_wb_payload_t;

endpackage

`default_nettype wire

/* source/stage_reg.sv */
// pipeline register that loads only while move is high
// reset clears the valid flag and leaves the payload as is
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      move,
    input  wire logic      in_valid,
    input  wire payload_t  in_payload,
    output logic           out_valid,
    output payload_t       out_payload
);

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (move) begin
            out_valid <= in_valid;
        end
    end

    // payload only meaningful while out_valid is set
    always_ff @(posedge clk) begin
        if (move) begin
            out_payload <= in_payload;
        end
    end

endmodule

`default_nettype wire

/* testbench/mem_golden.txt */
# columns: name valid we re funct3 address store_data rd exp_rd_we exp_rd_wdata
# funct3 0 b, 1 h, 2 w, 4 bu, 5 hu; address, data and result in hex, the rest decimal
# memory starts at zero, loads see every earlier store merged lane by lane
alu_first       1 0 0 0 12345678 00000000  1 1 12345678
sw_w100         1 1 0 2 00000100 deadbeef  2 0 00000100
lw_w100         1 0 1 2 00000100 00000000  3 1 deadbeef
alu_rd0         1 0 0 0 0000abcd 00000000  0 0 0000abcd
bubble_a        0 0 0 0 00000000 00000000  0 0 00000000
sb_b104         1 1 0 0 00000104 000000a1  4 0 00000104
sb_b105         1 1 0 0 00000105 ffffffb2  4 0 00000105
lw_w104_half    1 0 1 2 00000104 00000000  5 1 0000b2a1
sb_b106         1 1 0 0 00000106 123456c3  4 0 00000106
sb_b107         1 1 0 0 00000107 000000d4  4 0 00000107
lw_w104_full    1 0 1 2 00000104 00000000  5 1 d4c3b2a1
sh_h108         1 1 0 1 00000108 11117e5f  6 0 00000108
lw_w108_low     1 0 1 2 00000108 00000000  7 1 00007e5f
sh_h10a         1 1 0 1 0000010a 2222f00d  6 0 0000010a
lw_w108_full    1 0 1 2 00000108 00000000  7 1 f00d7e5f
sb_b102         1 1 0 0 00000102 00000055  8 0 00000102
sh_h100         1 1 0 1 00000100 abcd1234  8 0 00000100
lw_w100_merge   1 0 1 2 00000100 00000000  9 1 de551234
bubble_b        0 0 0 0 00000000 00000000  0 0 00000000
lb_b104         1 0 1 0 00000104 00000000 10 1 ffffffa1
lb_b105         1 0 1 0 00000105 00000000 11 1 ffffffb2
lb_b106         1 0 1 0 00000106 00000000 12 1 ffffffc3
lb_b107         1 0 1 0 00000107 00000000 13 1 ffffffd4
lbu_b104        1 0 1 4 00000104 00000000 14 1 000000a1
lbu_b105        1 0 1 4 00000105 00000000 15 1 000000b2
lbu_b106        1 0 1 4 00000106 00000000 16 1 000000c3
lbu_b107        1 0 1 4 00000107 00000000 17 1 000000d4
lb_b101         1 0 1 0 00000101 00000000 18 1 00000012
lb_b103         1 0 1 0 00000103 00000000 19 1 ffffffde
lh_h108         1 0 1 1 00000108 00000000 21 1 00007e5f
lh_h10a         1 0 1 1 0000010a 00000000 22 1 fffff00d
lhu_h108        1 0 1 5 00000108 00000000 23 1 00007e5f
lhu_h10a        1 0 1 5 0000010a 00000000 24 1 0000f00d
lh_h102         1 0 1 1 00000102 00000000 25 1 ffffde55
lhu_h100        1 0 1 5 00000100 00000000 26 1 00001234
alu_neg         1 0 0 0 ffff0000 00000000 31 1 ffff0000
sw_w10c         1 1 0 2 0000010c cafef00d  3 0 0000010c
lw_w10c_rd0     1 0 1 2 0000010c 00000000  0 0 cafef00d
lw_w10c         1 0 1 2 0000010c 00000000 20 1 cafef00d

/* testbench/mem_stage_tb.sv */
// testbench for mem_stage_top, stimulus and expected writeback from testbench/mem_golden.txt
// run from the project root; move is random, results are matched in order on move-high edges
`default_nettype none

module mem_stage_tb;

    localparam int max_lines      = 64;
    localparam int timeout_cycles = 64;
    localparam int drain_cycles   = 12;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_mem_we;
    logic        in_mem_re;
    logic [2:0]  in_funct3;
    logic [31:0] in_alu_out;
    logic [31:0] in_rs2_v;
    logic [4:0]  in_rd;
    logic        move;
    logic        wb_valid;
    logic        rd_we;
    logic [4:0]  rd_addr;
    logic [31:0] rd_wdata;

    // one entry per golden line
    logic [8*24-1:0] line_name [max_lines];
    logic            line_valid [max_lines];
    logic            line_we [max_lines];
    logic            line_re [max_lines];
    logic [2:0]      line_f3 [max_lines];
    logic [31:0]     line_addr [max_lines];
    logic [31:0]     line_data [max_lines];
    logic [4:0]      line_rd [max_lines];
    logic            exp_rd_we [max_lines];
    logic [31:0]     exp_wdata [max_lines];
    int              n_lines;
    // golden lines that must show up at writeback, in order
    int              exp_idx [$];

    mem_stage_top #(.addr_bits(8)) DUT (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_mem_we  (in_mem_we),
        .in_mem_re  (in_mem_re),
        .in_funct3  (in_funct3),
        .in_alu_out (in_alu_out),
        .in_rs2_v   (in_rs2_v),
        .in_rd      (in_rd),
        .move       (move),
        .wb_valid   (wb_valid),
        .rd_we      (rd_we),
        .rd_addr    (rd_addr),
        .rd_wdata   (rd_wdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic report_failure(input string text);
        $display("%s", text);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [8*24-1:0] test_name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected)
            else report_failure($sformatf("Mismatch %0s %0s expected %h actual %h",
                                          test_name, field, expected, actual));
    endtask

    // high about 70 percent of the time
    function automatic logic draw_move();
        return ($urandom % 100) < 70;
    endfunction

    task automatic load_golden();
        int              fd;
        int              n;
        string           text;
        logic [8*24-1:0] name;
        int              v;
        int              we;
        int              re;
        int              f3;
        int              rd;
        int              ewe;
        logic [31:0]     addr;
        logic [31:0]     data;
        logic [31:0]     edata;
        fd = $fopen("testbench/mem_golden.txt", "r");
        assert (fd != 0)
            else report_failure("cannot open testbench/mem_golden.txt");
        n_lines = 0;
        while (!$feof(fd) && n_lines < max_lines) begin
            n = $fgets(text, fd);
            if (n == 0 || text.len() == 0 || text[0] == "#") begin
                continue;
            end
            n = $sscanf(text, "%s %d %d %d %d %h %h %d %d %h",
                        name, v, we, re, f3, addr, data, rd, ewe, edata);
            if (n == 10) begin
                line_name[n_lines]  = name;
                line_valid[n_lines] = v[0];
                line_we[n_lines]    = we[0];
                line_re[n_lines]    = re[0];
                line_f3[n_lines]    = f3[2:0];
                line_addr[n_lines]  = addr;
                line_data[n_lines]  = data;
                line_rd[n_lines]    = rd[4:0];
                exp_rd_we[n_lines]  = ewe[0];
                exp_wdata[n_lines]  = edata;
                if (v[0]) begin
                    exp_idx.push_back(n_lines);
                end
                n_lines++;
            end else if (n > 0) begin
                report_failure($sformatf("malformed golden line: %0s", text));
            end
        end
        $fclose(fd);
    endtask

    // past the last line the pipeline is fed bubbles
    task automatic drive_line(input int idx);
        if (idx < n_lines) begin
            in_valid   <= line_valid[idx];
            in_mem_we  <= line_we[idx];
            in_mem_re  <= line_re[idx];
            in_funct3  <= line_f3[idx];
            in_alu_out <= line_addr[idx];
            in_rs2_v   <= line_data[idx];
            in_rd      <= line_rd[idx];
        end else begin
            in_valid   <= 1'b0;
            in_mem_we  <= 1'b0;
            in_mem_re  <= 1'b0;
        end
    endtask

    initial begin
        int          k;
        int          checked;
        int          moved_edges;
        int          idle;
        int          line_idx;
        logic        move_now;
        logic        have_prev;
        logic        prev_move;
        logic        prev_wb_valid;
        logic        prev_rd_we;
        logic [4:0]  prev_rd_addr;
        logic [31:0] prev_rd_wdata;

        void'($urandom(32'hcac8));
        reset      = 1'b1;
        move       = 1'b0;
        in_valid   = 1'b0;
        in_mem_we  = 1'b0;
        in_mem_re  = 1'b0;
        in_funct3  = 3'd0;
        in_alu_out = 32'd0;
        in_rs2_v   = 32'd0;
        in_rd      = 5'd0;

        load_golden();
        assert (exp_idx.size() > 0)
            else report_failure("golden file holds no valid instruction");

        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        reset <= 1'b0;
        line_idx = 0;
        drive_line(line_idx);
        move <= draw_move();

        checked     = 0;
        moved_edges = 0;
        idle        = 0;
        have_prev   = 1'b0;
        while (checked < exp_idx.size()) begin
            @(negedge clk);
            move_now = move;
            assert (wb_valid || !rd_we)
                else report_failure("rd_we is high while wb_valid is low");
            if (moved_edges < 2) begin
                assert (!wb_valid && !rd_we)
                    else report_failure("writeback seen before two move-high edges");
            end
            // a stall edge must leave the outputs alone
            if (have_prev && !prev_move) begin
                assert (wb_valid === prev_wb_valid && rd_we === prev_rd_we &&
                        rd_addr === prev_rd_addr && rd_wdata === prev_rd_wdata)
                    else report_failure("writeback outputs changed while move was low");
            end
            if (move_now && wb_valid) begin
                k = exp_idx[checked];
                check_value(line_name[k], "rd_we", {31'd0, exp_rd_we[k]}, {31'd0, rd_we});
                check_value(line_name[k], "rd_addr", {27'd0, line_rd[k]}, {27'd0, rd_addr});
                check_value(line_name[k], "rd_wdata", exp_wdata[k], rd_wdata);
                checked++;
                idle = 0;
            end else begin
                idle++;
                assert (idle < timeout_cycles)
                    else report_failure($sformatf("timeout waiting for the writeback of %0s",
                                                  line_name[exp_idx[checked]]));
            end
            have_prev     = 1'b1;
            prev_move     = move_now;
            prev_wb_valid = wb_valid;
            prev_rd_we    = rd_we;
            prev_rd_addr  = rd_addr;
            prev_rd_wdata = rd_wdata;

            @(posedge clk);
            if (move_now) begin
                moved_edges++;
                line_idx++;
                drive_line(line_idx);
            end
            move <= draw_move();
        end

        // nothing may come out once every result has been seen
        for (int i = 0; i < drain_cycles; i++) begin
            @(negedge clk);
            assert (!(move && wb_valid))
                else report_failure("writeback seen after the last expected result");
            @(posedge clk);
            move <= draw_move();
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
